//--- src/note_classifier.sv
`timescale 1ns/1ps

module note_classifier
(
    input                                   clk,
    input                                   rst,

    // From the period timer
    input        [note_pkg::w_period - 1:0] period,
    input                                   period_valid,

    // Classification result
    output note_pkg::note_t                 note_class,
    output logic                            class_valid
);

    // ------------------------------------------------------------------
    // Tolerance bound
    // ------------------------------------------------------------------

    // Integer divide before the percent scale
    function automatic logic [note_pkg::w_period - 1:0] bound
    (
        input int unsigned freq_100,
        input int unsigned pct
    );
        int unsigned full;

        full  = note_pkg::clk_mhz * 1000 * 1000 / freq_100 * pct;
        bound = full[note_pkg::w_period - 1:0];
    endfunction

    // ------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------

    note_pkg::classify_state_t state;

    logic [3:0]                      idx;       // Table entry under test
    logic [note_pkg::w_period - 1:0] period_q;  // Latched period
    note_pkg::note_t                 best;      // First hit so far
    note_pkg::note_t                 cand;      // Best after this step

    logic [note_pkg::w_period - 1:0] lo_bound [note_pkg::n_octaves];
    logic [note_pkg::w_period - 1:0] hi_bound [note_pkg::n_octaves];
    logic [note_pkg::n_octaves - 1:0] oct_hit;
    logic                             saturated;
    logic                             hit;
    logic                             last_step;

    // Window bounds for entry idx with one pair per octave
    // Constant table, so each branch folds into a small ROM
    always_comb
    begin
        for (int o = 0; o < note_pkg::n_octaves; o++)
        begin
            lo_bound[o] = '0;
            hi_bound[o] = '0;
        end

        for (int i = 0; i < note_pkg::n_notes; i++)
        begin
            if (idx == 4'(i))
            begin
                for (int o = 0; o < note_pkg::n_octaves; o++)
                begin
                    lo_bound[o] = bound(note_pkg::note_freq_100[i] << o,
                                        note_pkg::tol_low_pct);
                    hi_bound[o] = bound(note_pkg::note_freq_100[i] << o,
                                        note_pkg::tol_high_pct);
                end
            end
        end
    end

    // Strictly inside any window
    always_comb
        for (int o = 0; o < note_pkg::n_octaves; o++)
            oct_hit[o] = (period_q > lo_bound[o]) && (period_q < hi_bound[o]);

    assign saturated = &period_q;                 // No crossing in range
    assign hit       = (|oct_hit) && !saturated;
    assign last_step = (idx == 4'(note_pkg::n_notes - 1));

    // First matching entry wins
    assign cand = (best == note_pkg::note_none && hit)
                ? note_pkg::note_t'(idx + 4'd1)
                : best;

    // ------------------------------------------------------------------
    // FSM stepping one table entry per cycle
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state       <= note_pkg::idle;
            idx         <= '0;
            class_valid <= 1'b0;
        end
        else
        begin
            class_valid <= 1'b0;

            case (state)
                note_pkg::idle:
                    if (period_valid)
                    begin
                        idx   <= '0;
                        state <= note_pkg::search;
                    end

                note_pkg::search:   // period_valid dropped here
                    if (last_step)
                    begin
                        class_valid <= 1'b1;    // 12 steps done
                        state       <= note_pkg::idle;
                    end
                    else
                        idx <= idx + 4'd1;

                default:
                    state <= note_pkg::idle;
            endcase
        end

    // Datapath
    always_ff @(posedge clk)
        if (state == note_pkg::idle && period_valid)
        begin
            period_q <= period;
            best     <= note_pkg::note_none;
        end
        else if (state == note_pkg::search)
        begin
            best <= cand;
            if (last_step)
                note_class <= cand;
        end

endmodule

//--- src/note_filter.sv
`timescale 1ns/1ps

module note_filter
(
    input                   clk,
    input                   rst,

    // From the classifier
    input  note_pkg::note_t note_class,
    input                   class_valid,

    // Committed note
    output note_pkg::note_t note
);

    // ------------------------------------------------------------------
    // Run counting
    // ------------------------------------------------------------------

    note_pkg::note_t last_class;    // Previous classification

    logic [$clog2(note_pkg::filter_runs + 1) - 1:0] run_cnt;
    logic [$clog2(note_pkg::filter_runs + 1) - 1:0] run_next;
    logic commit;                   // Run just completed

    always_comb
        if (note_class != last_class)
            run_next = 1'b1;                    // New run starts
        else if (run_cnt == note_pkg::filter_runs)
            run_next = run_cnt;                 // Saturate
        else
            run_next = run_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            last_class <= note_pkg::note_none;
            run_cnt    <= '0;
            commit     <= 1'b0;
        end
        else
        begin
            commit <= class_valid && (run_next == note_pkg::filter_runs);

            if (class_valid)
            begin
                last_class <= note_class;
                run_cnt    <= run_next;
            end
        end

    // ------------------------------------------------------------------
    // Commit, note_none runs included
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
            note <= note_pkg::note_none;
        else if (commit)
            note <= last_class;     // Held until the next full run

endmodule

//--- src/note_pkg.sv
package note_pkg;

    // ------------------------------------------------------------------
    // System clock and datapath widths
    // ------------------------------------------------------------------

    localparam int clk_mhz  = 50;   // System clock in MHz
    localparam int w_mic    = 24;   // Signed microphone sample
    localparam int w_period = 20;   // All ones means no crossing in range

    // ------------------------------------------------------------------
    // Note search
    // ------------------------------------------------------------------

    localparam int n_notes   = 12;  // Semitones per octave
    localparam int n_octaves = 3;   // Table frequency times 1, 2 and 4

    // Consecutive identical classifications before a note is committed
    localparam int filter_runs = 4;

    // Window around the nominal period, in percent
    // Bound = (clk in Hz / freq in centihertz) * pct, divide first
    localparam int tol_low_pct  = 97;
    localparam int tol_high_pct = 103;

    // Note frequencies in centihertz, C through B
    localparam int unsigned note_freq_100 [n_notes] = '{
        26163,  // C
        27718,  // C#
        29366,  // D
        31113,  // D#
        32963,  // E
        34923,  // F
        36999,  // F#
        39200,  // G
        41530,  // G#
        44000,  // A
        46616,  // A#
        49388   // B
    };

    // ------------------------------------------------------------------
    // Enumerations
    // ------------------------------------------------------------------

    // Table entry i maps to value i + 1
    typedef enum logic [3:0]
    {
        note_none,
        note_c,
        note_cs,
        note_d,
        note_ds,
        note_e,
        note_f,
        note_fs,
        note_g,
        note_gs,
        note_a,
        note_as,
        note_b
    } note_t;

    typedef enum logic
    {
        idle,    // Waiting for a period
        search   // Walking the note table
    } classify_state_t;

endpackage

//--- src/note_segment_encoder.sv
`timescale 1ns/1ps

module note_segment_encoder
(
    input                   clk,
    input                   rst,

    input  note_pkg::note_t note,       // Committed note

    output logic [7:0]      abcdefgh,   // Segments, h is the dot
    output logic [7:0]      digit       // Digit select, one-hot
);

    // ------------------------------------------------------------------
    // Segment layout
    //
    //     --a--
    //    |     |
    //    f     b
    //     --g--
    //    e     c
    //    |     |
    //     --d--  h
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
            abcdefgh <= 8'b0000_0000;
        else
            case (note)
                note_pkg::note_c  : abcdefgh <= 8'b1001_1100;  // C
                note_pkg::note_cs : abcdefgh <= 8'b1001_1101;  // C and dot
                note_pkg::note_d  : abcdefgh <= 8'b0111_1010;  // Lower case d
                note_pkg::note_ds : abcdefgh <= 8'b0111_1011;
                note_pkg::note_e  : abcdefgh <= 8'b1001_1110;  // E
                note_pkg::note_f  : abcdefgh <= 8'b1000_1110;  // F
                note_pkg::note_fs : abcdefgh <= 8'b1000_1111;
                note_pkg::note_g  : abcdefgh <= 8'b1011_1100;  // G
                note_pkg::note_gs : abcdefgh <= 8'b1011_1101;
                note_pkg::note_a  : abcdefgh <= 8'b1110_1110;  // A
                note_pkg::note_as : abcdefgh <= 8'b1110_1111;
                note_pkg::note_b  : abcdefgh <= 8'b0011_1110;  // Lower case b

                // No note, blank
                default           : abcdefgh <= 8'b0000_0000;
            endcase

    // Single digit, always the rightmost
    assign digit = 8'b0000_0001;

endmodule

//--- src/note_tuner_top.sv
`timescale 1ns/1ps

module note_tuner_top
(
    input                                   clk,
    input                                   rst,

    // Microphone stream
    input        [note_pkg::w_mic - 1:0]    mic,
    input                                   mic_ready,

    // Observation points
    output logic [note_pkg::w_period - 1:0] period,
    output logic                            period_valid,
    output note_pkg::note_t                 note,

    // Seven-segment display
    output logic [7:0]                      abcdefgh,
    output logic [7:0]                      digit
);

    // ------------------------------------------------------------------
    // Chain wiring
    // ------------------------------------------------------------------

    note_pkg::note_t note_class;   // Raw per-period result
    logic            class_valid;

    zero_cross_period i_period
    (
        .clk, .rst, .mic, .mic_ready, .period, .period_valid
    );

    // 13 cycles per classification
    note_classifier i_classifier
    (
        .clk, .rst, .period, .period_valid, .note_class, .class_valid
    );

    note_filter i_filter
    (
        .clk, .rst, .note_class, .class_valid, .note
    );

    note_segment_encoder i_segments
    (
        .clk, .rst, .note, .abcdefgh, .digit
    );

endmodule

//--- src/zero_cross_period.sv
`timescale 1ns/1ps

module zero_cross_period
(
    input                                 clk,
    input                                 rst,

    // Microphone stream
    input        [note_pkg::w_mic - 1:0]    mic,
    input                                   mic_ready,  // Sample strobe

    // Measured period, clk cycles between crossings
    output logic [note_pkg::w_period - 1:0] period,
    output logic                            period_valid
);

    // ------------------------------------------------------------------
    // Crossing detect
    // ------------------------------------------------------------------

    logic sign_q;                               // Sign of previous sample
    logic [note_pkg::w_period - 1:0] count;     // Free-running cycle count
    logic crossing;

    // Negative to positive, only on a fresh sample
    assign crossing = mic_ready
                    & sign_q
                    & ~mic[note_pkg::w_mic - 1];

    // ------------------------------------------------------------------
    // Control and counter
    // ------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            sign_q       <= 1'b0;   // Positive, so no false crossing
            count        <= '0;
            period_valid <= 1'b0;
        end
        else
        begin
            period_valid <= crossing;   // One cycle after the sample

            if (mic_ready)
                sign_q <= mic[note_pkg::w_mic - 1];

            // Crossing cycle counts as the first of the next period
            if (crossing)
                count <= {{(note_pkg::w_period - 1){1'b0}}, 1'b1};
            else if (count != '1)                   // Saturate at all ones
                count <= count + 1'b1;
        end

    // ------------------------------------------------------------------
    // Published period
    // ------------------------------------------------------------------

    // Holds until the next crossing
    always_ff @(posedge clk)
        if (crossing)
            period <= count;

endmodule

//--- verification/tb_note_tuner.sv
`timescale 1ns/1ps

module tb_note_tuner;

    // ------------------------------------------------------------------
    // DUT signals and testbench state
    // ------------------------------------------------------------------

    logic                            clk;
    logic                            rst;
    logic [note_pkg::w_mic - 1:0]    mic;
    logic                            mic_ready;
    logic [note_pkg::w_period - 1:0] period;
    logic                            period_valid;
    note_pkg::note_t                 note;
    logic [7:0]                      abcdefgh;
    logic [7:0]                      digit;

    integer seed;                   // $random state
    int     cyc = 0;                // Free-running cycle index
    int     limit;                  // Timeout in cycles
    int     last_cross;             // Cycle of last driven crossing
    logic   last_neg = 1'b0;        // Sign of last driven sample

    int period_errors = 0;
    int note_errors   = 0;
    int seg_errors    = 0;
    int other_errors  = 0;

    logic [note_pkg::w_period - 1:0] exp_periods [$];   // One per crossing
    logic [note_pkg::w_period - 1:0] exp_p;
    int                              exp_cycles [$];    // period_valid cycle per crossing
    int                              exp_c;

    // Filter model
    note_pkg::note_t model_note   = note_pkg::note_none;    // Expected on note
    note_pkg::note_t pending_note = note_pkg::note_none;
    note_pkg::note_t last_cls     = note_pkg::note_none;
    note_pkg::note_t cls;
    note_pkg::note_t note_seen    = note_pkg::note_none;
    logic [7:0]      model_seg    = 8'h00;                  // Expected on abcdefgh
    logic [7:0]      seg_seen     = 8'h00;
    int              run          = 0;
    int              commit_due   = -1;

    note_tuner_top UUT
    (
        .clk, .rst, .mic, .mic_ready, .period, .period_valid, .note, .abcdefgh, .digit
    );

    always #10 clk = ~clk;                  // 20 ns period
    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // First hit wins across the three octave windows
    function automatic note_pkg::note_t expected_note(input int unsigned p);
        int unsigned f;
        int unsigned lo;
        int unsigned hi;

        if (p >= (1 << note_pkg::w_period) - 1)
            return note_pkg::note_none;     // Nothing in range
        for (int i = 0; i < note_pkg::n_notes; i++)
            for (int o = 0; o < note_pkg::n_octaves; o++)
            begin
                f  = note_pkg::note_freq_100[i] << o;
                lo = (note_pkg::clk_mhz * 1000000 / f) * note_pkg::tol_low_pct;
                hi = (note_pkg::clk_mhz * 1000000 / f) * note_pkg::tol_high_pct;
                if (p > lo && p < hi)
                    return note_pkg::note_t'(i + 1);
            end
        return note_pkg::note_none;
    endfunction

    // Letter shapes with the dot for sharps
    function automatic logic [7:0] segment_pattern(input note_pkg::note_t n);
        case (n)
            note_pkg::note_c  : return 8'b1001_1100;
            note_pkg::note_cs : return 8'b1001_1101;
            note_pkg::note_d  : return 8'b0111_1010;
            note_pkg::note_ds : return 8'b0111_1011;
            note_pkg::note_e  : return 8'b1001_1110;
            note_pkg::note_f  : return 8'b1000_1110;
            note_pkg::note_fs : return 8'b1000_1111;
            note_pkg::note_g  : return 8'b1011_1100;
            note_pkg::note_gs : return 8'b1011_1101;
            note_pkg::note_a  : return 8'b1110_1110;
            note_pkg::note_as : return 8'b1110_1111;
            note_pkg::note_b  : return 8'b0011_1110;
            default           : return 8'b0000_0000;    // Blank
        endcase
    endfunction

    // Nominal period of table entry i at octave multiplier 2**o
    function automatic int nominal_period(input int i, input int o);
        return (note_pkg::clk_mhz * 1000000 / (note_pkg::note_freq_100[i] << o)) * 100;
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------

    task automatic check_period(input logic [note_pkg::w_period - 1:0] expected,
                                input logic [note_pkg::w_period - 1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] period: expected %h, got %h", expected, actual);
            period_errors++;
        end
    endtask

    task automatic check_note(input note_pkg::note_t expected, input note_pkg::note_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] note: expected %h, got %h", expected, actual);
            note_errors++;
        end
    endtask

    task automatic check_segments(input string name, input logic [7:0] expected,
                                  input logic [7:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
            seg_errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    // One sample per cycle with a random magnitude
    task automatic drive_sample(input logic neg);
        int          raw;
        int          gap;
        logic [22:0] mag;

        raw = $random(seed);
        mag = raw[22:0];
        @(posedge clk);
        mic       <= neg ? ~{1'b0, mag} : {1'b0, mag};
        mic_ready <= 1'b1;
        if (!neg && last_neg)                       // Negative to positive
        begin
            gap = cyc - last_cross;
            if (gap >= (1 << note_pkg::w_period) - 1)
                exp_periods.push_back('1);          // Saturated
            else
                exp_periods.push_back(gap[note_pkg::w_period - 1:0]);
            exp_cycles.push_back(cyc + 2);          // Sample next cycle, pulse after
            last_cross = cyc;
        end
        last_neg = neg;
    endtask

    task automatic drive_half(input logic neg, input int len);
        repeat (len) drive_sample(neg);
    endtask

    // Square tone crossing at the start of each positive half
    task automatic play_tone(input int p, input int n);
        repeat (n)
        begin
            drive_half(1'b1, p / 2);
            drive_half(1'b0, p - p / 2);
        end
    endtask

    // Commit long done by the end of the last positive half
    task automatic tone_test(input int p, input int n, input note_pkg::note_t want);
        play_tone(p, n);
        check_note(want, note);
        check_segments("abcdefgh", segment_pattern(want), abcdefgh);
    endtask

    // Same sequence as the initial block below
    function automatic int run_budget();
        int a4;
        int cs4;

        a4  = nominal_period(9, 2);
        cs4 = nominal_period(1, 2);
        return 50 + 5 * (a4 + nominal_period(9, 1) + nominal_period(9, 0) + cs4)
             + 5 * 22000 + 5 * a4 + 4 * cs4 + 5 * a4 + 5 * cs4
             + cs4 / 2 + 100 + 3 * 200 + 4 * (1 << note_pkg::w_period) + 1100 + 20;
    endfunction

    // ------------------------------------------------------------------
    // Monitor for periods and the filter model
    // ------------------------------------------------------------------

    always @(posedge clk)
        if (!rst)
        begin
            if (cyc == commit_due)
                model_note = pending_note;
            if (cyc == commit_due + 1)
                model_seg = segment_pattern(model_note);    // Display lags by one
            if (period_valid)
            begin
                if (exp_periods.size() == 0)
                begin
                    $display("period_valid seen with no crossing driven, cycle %0d", cyc);
                    other_errors++;
                end
                else
                begin
                    exp_p = exp_periods.pop_front();
                    exp_c = exp_cycles.pop_front();
                    if (cyc != exp_c)
                    begin
                        $display("period_valid in cycle %0d instead of cycle %0d",
                                 cyc, exp_c);
                        other_errors++;
                    end
                    check_period(exp_p, period);
                    cls = expected_note(exp_p);
                    if (cls != last_cls)
                        run = 1;                    // New run
                    else if (run < note_pkg::filter_runs)
                        run++;
                    last_cls = cls;
                    if (run == note_pkg::filter_runs)
                    begin
                        pending_note = cls;
                        commit_due   = cyc + 15;    // Classifier 13, filter 2
                    end
                end
            end
            if (note !== note_seen || cyc == commit_due)
                check_note(model_note, note);
            if (abcdefgh !== seg_seen || cyc == commit_due + 1)
                check_segments("abcdefgh", model_seg, abcdefgh);
            note_seen = note;
            seg_seen  = abcdefgh;
        end

    // Run length guard
    always @(posedge clk)
        if (cyc > limit)
        begin
            $display("Timeout: test did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial
    begin
        limit     = run_budget() * 11 / 10;
        seed      = 75;
        clk       = 1'b0;
        rst       = 1'b1;
        mic       = '0;
        mic_ready = 1'b0;

        repeat (3) @(posedge clk);
        rst        <= 1'b0;
        last_cross  = cyc;                  // Counter starts here

        // Reset state and then silence
        check_note(note_pkg::note_none, note);
        check_segments("abcdefgh", 8'h00, abcdefgh);
        check_segments("digit", 8'h01, digit);
        drive_half(1'b0, 50);

        // A at three octaves and a high C sharp
        tone_test(nominal_period(9, 2), 5, expected_note(nominal_period(9, 2)));
        tone_test(nominal_period(9, 1), 5, expected_note(nominal_period(9, 1)));
        tone_test(nominal_period(9, 0), 5, expected_note(nominal_period(9, 0)));
        tone_test(nominal_period(1, 2), 5, expected_note(nominal_period(1, 2)));

        // Below every window
        tone_test(22000, 5, note_pkg::note_none);

        // Three C sharp results between A runs
        tone_test(nominal_period(9, 2), 5, note_pkg::note_a);
        tone_test(nominal_period(1, 2), 4, note_pkg::note_a);
        tone_test(nominal_period(9, 2), 5, note_pkg::note_a);
        tone_test(nominal_period(1, 2), 5, note_pkg::note_cs);

        // One more C sharp period, then four saturated ones from long positive holds
        for (int k = 0; k < 5; k++)
        begin
            drive_half(1'b1, (k == 0) ? nominal_period(1, 2) / 2 : 100);
            drive_half(1'b0, (k < 4) ? (1 << note_pkg::w_period) + 100 : 1000);
        end
        check_note(note_pkg::note_none, note);
        check_segments("abcdefgh", 8'h00, abcdefgh);

        repeat (20) @(posedge clk);
        if (exp_periods.size() != 0)
        begin
            $display("%0d crossings never produced period_valid", exp_periods.size());
            other_errors++;
        end

        $display("Errors: period %0d, note %0d, segments %0d, other %0d",
                 period_errors, note_errors, seg_errors, other_errors);
        if (period_errors + note_errors + seg_errors + other_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- verilog.f
src/note_pkg.sv
src/zero_cross_period.sv
src/note_classifier.sv
src/note_filter.sv
src/note_segment_encoder.sv
src/note_tuner_top.sv
verification/tb_note_tuner.sv
